// ==== vlog.f ====
hw/sd_host_pkg.sv
hw/transfer_fsm.sv
hw/transfer_counters.sv
hw/adma_reader.sv
hw/tx_buffer.sv
hw/dat_serializer.sv
hw/sd_host.sv
test/sd_host_assertions.sv
test/tb_sd_host.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the SD host testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
   --top-module tb_sd_host \
   -f vlog.f \
   -o sim_tb_sd_host

./obj_dir/sim_tb_sd_host | tee sim.log

if grep -qx "No errors" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// ==== test/tb_sd_host.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the SD host write path, RAM model and card decoder
// RAM holds 256 words, start addresses stay inside it
// card busy is modeled per block, timeouts use busy well past the limit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_sd_host import sd_host_pkg::*; ();

   localparam int          CLK_PERIOD   = 20;
   localparam int          RESET_CYCLES = 4;
   localparam int          RAM_WORDS    = 256;
   localparam logic [31:0] LFSR_SEED    = 32'd66167;
   localparam int          N_RANDOM     = 6;
   localparam int          STALL_BUSY   = 48;   // long, still below the timeout
   localparam int          LONG_BUSY    = 100;  // well past BUSY_TIMEOUT
   localparam int          DATA_NIBBLES = BLOCK_WORDS * 8;
   localparam int          FRAME_LEN    = 1 + DATA_NIBBLES + CRC_BITS + 1;
   localparam int          WATCHDOG_CYCLES = (N_RANDOM + 3) * 4 * (FRAME_LEN + LONG_BUSY + 20)
                                             + 4 * LONG_BUSY;

   logic              clk = 1'b0;
   logic              arst_n = 1'b0;
   logic              start = 1'b0;
   logic [ADDR_W-1:0] start_address = '0;
   logic [CNT_W-1:0]  block_count = '0;
   logic [WORD_W-1:0] data_from_ram = '0;
   logic              card_busy = 1'b0;
   logic              busy;
   logic              done;
   logic              error;
   logic              ram_read_enable;
   logic [ADDR_W-1:0] ram_address;
   logic [3:0]        data_to_card;
   logic              data_to_card_oe;

   logic [31:0] lfsr;
   logic [31:0] ram_model [RAM_WORDS];
   int          busy_plan [4];          // card busy cycles after each block
   int          errors = 0;
   int          transfers = 0;
   int          total_blocks = 0;

   // card and RAM model state
   logic        pend_read = 1'b0;
   logic [31:0] pend_addr = '0;
   logic [7:0]  cur_idx = '0;          // next expected word
   logic [31:0] exp_shift;
   logic [31:0] rx_word;
   logic [15:0] exp_crc [4];
   int          frame_pos = 0;
   int          nib_pos = 0;
   int          busy_left = 0;
   int          reads_issued = 0;
   int          words_sent = 0;
   int          blocks_seen = 0;
   int          peak = 0;
   int          last_blocks = 0;
   int          last_peak = 0;

   sd_host i_sd_host (
      .clk             (clk),
      .arst_n          (arst_n),
      .start           (start),
      .start_address   (start_address),
      .block_count     (block_count),
      .busy            (busy),
      .done            (done),
      .error           (error),
      .ram_read_enable (ram_read_enable),
      .ram_address     (ram_address),
      .data_from_ram   (data_from_ram),
      .data_to_card    (data_to_card),
      .data_to_card_oe (data_to_card_oe),
      .card_busy       (card_busy)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////////////////////////

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] value);
      value = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         value = {value[30:0], lfsr[0]};
      end
   endtask

   // x^16 + x^12 + x^5 + 1, one bit in
   function automatic logic [15:0] crc16_next(input logic [15:0] c, input logic b);
      if (c[15] ^ b) return (c << 1) ^ 16'h1021;
      return c << 1;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      errors++;
      $display("[ERROR] %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("[ERROR] %0d ns: %s", $time, what);
   endtask

   task automatic check_idle_outputs();
      if (busy !== 1'b0) report_mismatch("busy", 32'd0, 32'(busy));
      if (done !== 1'b0) report_mismatch("done", 32'd0, 32'(done));
      if (error !== 1'b0) report_mismatch("error", 32'd0, 32'(error));
      if (ram_read_enable !== 1'b0) begin
         report_mismatch("ram_read_enable", 32'd0, 32'(ram_read_enable));
      end
      if (data_to_card_oe !== 1'b0) begin
         report_mismatch("data_to_card_oe", 32'd0, 32'(data_to_card_oe));
      end
      if (data_to_card !== 4'hF) report_mismatch("data_to_card", 32'hF, 32'(data_to_card));
   endtask

   //////////////////////////////////////////////////////////////////////
   // RAM answer and card-side decoder, one process on the falling edge
   //////////////////////////////////////////////////////////////////////

   always @(negedge clk) begin
      logic        end_seen;
      logic [3:0]  exp_bits;
      logic [31:0] exp_addr;
      end_seen = 1'b0;
      if (!arst_n) begin
         pend_read = 1'b0;
         card_busy = 1'b0;
         frame_pos = 0;
      end else begin
         data_from_ram = pend_read ? ram_model[pend_addr[9:2]] : '0;  // one cycle late
         pend_read = ram_read_enable;
         pend_addr = ram_address;
         if (ram_read_enable) begin
            exp_addr = start_address + ADDR_W'(4 * reads_issued);  // ascending words
            if (ram_address !== exp_addr) report_mismatch("ram_address", exp_addr, ram_address);
            reads_issued++;
         end

         if (data_to_card_oe) begin
            if (frame_pos == 0) begin
               if (!busy) report_failure("start bit seen with no transfer running");
               if (card_busy) report_failure("start bit seen while card_busy is high");
               if (data_to_card !== 4'h0) report_mismatch("data_to_card start bit", 32'h0,
                                                          32'(data_to_card));
               for (int i = 0; i < 4; i++) exp_crc[i] = '0;
               nib_pos = 0;
            end else if (frame_pos <= DATA_NIBBLES) begin
               if (nib_pos == 0) begin
                  exp_shift = ram_model[cur_idx];
                  rx_word = '0;
               end
               rx_word = {rx_word[27:0], data_to_card};
               for (int i = 0; i < 4; i++) begin
                  exp_crc[i] = crc16_next(exp_crc[i], exp_shift[28 + i]);
               end
               exp_shift = exp_shift << 4;
               if (nib_pos == 7) begin
                  if (rx_word !== ram_model[cur_idx]) begin
                     report_mismatch("data_to_card word", ram_model[cur_idx], rx_word);
                  end
                  cur_idx = cur_idx + 8'd1;
                  words_sent++;
                  nib_pos = 0;
               end else begin
                  nib_pos++;
               end
            end else if (frame_pos <= DATA_NIBBLES + CRC_BITS) begin
               // line i carries bit 15 of its own CRC first
               for (int i = 0; i < 4; i++) exp_bits[i] = exp_crc[i][15];
               if (data_to_card !== exp_bits) begin
                  report_mismatch("data_to_card crc bits", 32'(exp_bits), 32'(data_to_card));
               end
               for (int i = 0; i < 4; i++) exp_crc[i] = exp_crc[i] << 1;
            end else begin
               if (data_to_card !== 4'hF) report_mismatch("data_to_card end bit", 32'hF,
                                                          32'(data_to_card));
               busy_left = busy_plan[blocks_seen[1:0]];
               end_seen = 1'b1;
               blocks_seen++;
            end
            frame_pos = (frame_pos == FRAME_LEN - 1) ? 0 : frame_pos + 1;
         end else begin
            if (frame_pos != 0) report_failure("data_to_card_oe dropped inside a block");
            frame_pos = 0;
            if (data_to_card !== 4'hF) report_mismatch("data_to_card idle", 32'hF,
                                                       32'(data_to_card));
         end

         // reads may run at most one buffer ahead of the bus
         if (reads_issued - words_sent > BUF_DEPTH) report_failure("RAM reads ran past the credits");
         if (reads_issued - words_sent > peak) peak = reads_issued - words_sent;

         if (!end_seen && busy_left > 0) busy_left--;
         card_busy = (busy_left != 0);

         if (done) begin
            last_blocks = blocks_seen;
            last_peak = peak;
            blocks_seen = 0;
            reads_issued = 0;
            words_sent = 0;
            peak = 0;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // transfers
   //////////////////////////////////////////////////////////////////////

   task automatic run_transfer(input int nblocks, input logic [7:0] word_idx,
                               input logic expect_error);
      int expected_blocks;
      @(negedge clk);
      cur_idx = word_idx;
      start_address = {22'd0, word_idx, 2'b00};
      block_count = CNT_W'(nblocks);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      if (busy !== 1'b1) report_mismatch("busy", 32'd1, 32'(busy));
      while (done !== 1'b1) @(negedge clk);
      if (error !== expect_error) report_mismatch("error", 32'(expect_error), 32'(error));
      @(negedge clk);
      if (done !== 1'b0) report_mismatch("done", 32'd0, 32'(done));
      if (busy !== 1'b0) report_mismatch("busy", 32'd0, 32'(busy));
      if (error !== expect_error) report_mismatch("error", 32'(expect_error), 32'(error));
      expected_blocks = expect_error ? 1 : nblocks;
      if (last_blocks != expected_blocks) report_mismatch("blocks sent", 32'(expected_blocks),
                                                          32'(last_blocks));
      transfers++;
      total_blocks += last_blocks;
   endtask

   task automatic random_transfer();
      logic [31:0] v;
      logic [7:0]  idx;
      int          nblocks;
      draw_bits(2, v);
      nblocks = int'(v[1:0]) + 1;
      draw_bits(7, v);
      idx = {1'b0, v[6:0]};
      for (int b = 0; b < 4; b++) begin
         draw_bits(5, v);
         busy_plan[b] = int'(v[4:0]);
      end
      run_transfer(nblocks, idx, 1'b0);
   endtask

   initial begin
      logic [31:0] v;
      lfsr = LFSR_SEED;
      for (int i = 0; i < RAM_WORDS; i++) begin
         draw_bits(32, v);
         ram_model[i] = v;
      end
      repeat (RESET_CYCLES) @(negedge clk);
      check_idle_outputs();
      arst_n = 1'b1;
      @(negedge clk);
      check_idle_outputs();

      for (int t = 0; t < N_RANDOM; t++) random_transfer();

      // long busy on every block, fetch must stall on credits
      for (int b = 0; b < 4; b++) busy_plan[b] = STALL_BUSY;
      run_transfer(4, 8'd40, 1'b0);
      if (last_peak != BUF_DEPTH) report_mismatch("outstanding reads peak", 32'(BUF_DEPTH),
                                                  32'(last_peak));

      // card busy past the limit after the first block
      busy_plan[0] = LONG_BUSY;
      for (int b = 1; b < 4; b++) busy_plan[b] = 0;
      run_transfer(3, 8'd100, 1'b1);
      repeat (LONG_BUSY) @(negedge clk);   // no frame may start meanwhile
      if (reads_issued != 0) report_failure("RAM reads continued after the timeout");
      random_transfer();

      $display("transfers: %0d, blocks: %0d, errors: %0d", transfers, total_blocks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired, a transfer never completed");
      $display("Errors found");
      $finish;
   end

endmodule

// ==== test/sd_host_assertions.sv ====
//////////////////////////////////////////////////////////////////////
// credit and buffer invariants of the RAM to DAT path
// bound into sd_host, reaches adma_reader and tx_buffer by instance
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sd_host_assertions import sd_host_pkg::*; (
   input logic             clk,
   input logic             arst_n,
   input logic [LVL_W-1:0] credits,
   input logic [LVL_W-1:0] fill_level,
   input logic             read_pending,
   input logic             buf_write,
   input logic             word_pop
);

   fill_in_range: assert property (@(posedge clk) disable iff (!arst_n)
      fill_level <= LVL_W'(BUF_DEPTH))
      else $error("buffer fill level above its depth");

   // every credit is either spare, in flight from RAM or a stored word
   credit_balance: assert property (@(posedge clk) disable iff (!arst_n)
      int'(credits) + int'(fill_level) + int'(read_pending) + int'(buf_write) == BUF_DEPTH)
      else $error("credits and buffered words out of balance");

   pop_not_empty: assert property (@(posedge clk) disable iff (!arst_n)
      word_pop |-> (fill_level != '0))
      else $error("word popped from an empty buffer");

endmodule

bind sd_host sd_host_assertions i_sd_host_assertions (
   .clk          (clk),
   .arst_n       (arst_n),
   .credits      (i_adma_reader.credits),
   .fill_level   (i_tx_buffer.fill_level),
   .read_pending (i_adma_reader.read_pending),
   .buf_write    (buf_write),
   .word_pop     (word_pop)
);

// ==== hw/sd_host.sv ====
//////////////////////////////////////////////////////////////////////
// SD host write path, RAM to 4-bit DAT bus, single clock domain
// data_from_ram must be valid exactly one cycle after ram_read_enable
// no command line, no read direction, config comes in on loose ports
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sd_host import sd_host_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              start,
   input  logic [ADDR_W-1:0] start_address,
   input  logic [CNT_W-1:0]  block_count,
   output logic              busy,
   output logic              done,
   output logic              error,
   output logic              ram_read_enable,
   output logic [ADDR_W-1:0] ram_address,
   input  logic [WORD_W-1:0] data_from_ram,
   output logic [3:0]        data_to_card,
   output logic              data_to_card_oe,
   input  logic              card_busy
);

   // control
   logic              load;
   logic              send_block;
   logic              busy_wait;
   logic              flush;
   logic              block_sent;
   logic              words_left_zero;
   logic              blocks_left_zero;
   logic              timeout_hit;

   // data path
   logic              word_read;
   logic              buf_write;
   logic [WORD_W-1:0] buf_data;
   logic              credit_return;
   logic              word_pop;
   logic [WORD_W-1:0] word_out;
   logic              block_ready;

   //////////////////////////////////////////////////////////////////////
   // sequencing
   //////////////////////////////////////////////////////////////////////

   transfer_fsm i_transfer_fsm (
      .clk              (clk),
      .arst_n           (arst_n),
      .start            (start),
      .card_busy        (card_busy),
      .block_ready      (block_ready),
      .block_sent       (block_sent),
      .blocks_left_zero (blocks_left_zero),
      .timeout_hit      (timeout_hit),
      .load             (load),
      .send_block       (send_block),
      .busy_wait        (busy_wait),
      .flush            (flush),
      .busy             (busy),
      .done             (done),
      .error            (error)
   );

   transfer_counters i_transfer_counters (
      .clk              (clk),
      .arst_n           (arst_n),
      .load             (load),
      .block_count      (block_count),
      .word_read        (word_read),
      .block_sent       (block_sent),
      .busy_wait        (busy_wait),
      .words_left_zero  (words_left_zero),
      .blocks_left_zero (blocks_left_zero),
      .timeout_hit      (timeout_hit)
   );

   //////////////////////////////////////////////////////////////////////
   // RAM -> buffer -> DAT
   //////////////////////////////////////////////////////////////////////

   adma_reader i_adma_reader (
      .clk             (clk),
      .arst_n          (arst_n),
      .load            (load),
      .start_address   (start_address),
      .words_left_zero (words_left_zero),
      .flush           (flush),
      .credit_return   (credit_return),
      .data_from_ram   (data_from_ram),
      .ram_read_enable (ram_read_enable),
      .ram_address     (ram_address),
      .word_read       (word_read),
      .buf_write       (buf_write),
      .buf_data        (buf_data)
   );

   tx_buffer i_tx_buffer (
      .clk           (clk),
      .arst_n        (arst_n),
      .flush         (flush),
      .buf_write     (buf_write),
      .buf_data      (buf_data),
      .word_pop      (word_pop),
      .word_out      (word_out),
      .block_ready   (block_ready),
      .credit_return (credit_return)
   );

   dat_serializer i_dat_serializer (
      .clk             (clk),
      .arst_n          (arst_n),
      .send_block      (send_block),
      .word_out        (word_out),
      .word_pop        (word_pop),
      .block_sent      (block_sent),
      .data_to_card    (data_to_card),
      .data_to_card_oe (data_to_card_oe)
   );

endmodule

// ==== hw/dat_serializer.sv ====
//////////////////////////////////////////////////////////////////////
// DAT block framer on 4 lines, start bit, data, CRC16 per line, end bit
// expects BLOCK_WORDS words ready in the buffer when send_block comes
// outputs decode straight from the phase register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dat_serializer import sd_host_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              send_block,
   input  logic [WORD_W-1:0] word_out,
   output logic              word_pop,
   output logic              block_sent,
   output logic [3:0]        data_to_card,
   output logic              data_to_card_oe
);

   dat_phase_t          phase;
   logic [NIB_W-1:0]    nib_cnt;    // nibble in DATA, crc bit in CRC
   logic [WCNT_W-1:0]   word_cnt;
   logic [CRC_BITS-1:0] crc [4];
   logic [3:0]          cur_nibble;
   logic                last_nibble;
   logic                last_word;

   // serial CRC16, MSB first
   function automatic logic [CRC_BITS-1:0] crc16_step(input logic [CRC_BITS-1:0] c,
                                                      input logic              b);
      logic fb;
      fb = c[CRC_BITS-1] ^ b;
      return {c[CRC_BITS-2:0], 1'b0} ^ (fb ? CRC_POLY : '0);
   endfunction

   assign cur_nibble      = word_out[4*(NIB_PER_WORD-1-int'(nib_cnt)) +: 4];  // msn first
   assign last_nibble     = (nib_cnt == NIB_W'(NIB_PER_WORD - 1));
   assign last_word       = (word_cnt == WCNT_W'(BLOCK_WORDS - 1));
   assign word_pop        = (phase == P_DATA) && last_nibble;
   assign block_sent      = (phase == P_STOP);
   assign data_to_card_oe = (phase != P_IDLE);

   always_comb begin
      unique case (phase)
         P_START: data_to_card = 4'h0;
         P_DATA:  data_to_card = cur_nibble;
         P_CRC:   data_to_card = {crc[3][CRC_BITS-1], crc[2][CRC_BITS-1],
                                  crc[1][CRC_BITS-1], crc[0][CRC_BITS-1]};
         default: data_to_card = 4'hF;   // idle high and end bit
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         phase    <= P_IDLE;
         nib_cnt  <= '0;
         word_cnt <= '0;
         for (int i = 0; i < 4; i++) crc[i] <= '0;
      end else begin
         unique case (phase)
            P_IDLE: begin
               if (send_block) phase <= P_START;
            end
            P_START: begin
               phase    <= P_DATA;
               nib_cnt  <= '0;
               word_cnt <= '0;
               for (int i = 0; i < 4; i++) crc[i] <= '0;  // init value zero
            end
            P_DATA: begin
               for (int i = 0; i < 4; i++) crc[i] <= crc16_step(crc[i], cur_nibble[i]);
               if (last_nibble) begin
                  nib_cnt  <= '0;
                  word_cnt <= word_cnt + 1'b1;
                  if (last_word) phase <= P_CRC;
               end else begin
                  nib_cnt <= nib_cnt + 1'b1;
               end
            end
            P_CRC: begin
               for (int i = 0; i < 4; i++) crc[i] <= {crc[i][CRC_BITS-2:0], 1'b0};
               nib_cnt <= nib_cnt + 1'b1;  // wraps to zero after bit 15
               if (nib_cnt == NIB_W'(CRC_BITS - 1)) phase <= P_STOP;
            end
            P_STOP:  phase <= P_IDLE;
            default: phase <= P_IDLE;
         endcase
      end
   end

endmodule

// ==== hw/tx_buffer.sv ====
//////////////////////////////////////////////////////////////////////
// transmit word FIFO, show-ahead read, no full flag
// the credit scheme upstream keeps writes within BUF_DEPTH
// words dropped by flush return no credit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tx_buffer import sd_host_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              flush,
   input  logic              buf_write,
   input  logic [WORD_W-1:0] buf_data,
   input  logic              word_pop,
   output logic [WORD_W-1:0] word_out,
   output logic              block_ready,
   output logic              credit_return
);

   logic [WORD_W-1:0] mem [BUF_DEPTH];
   logic [BUF_AW-1:0] wr_ptr;
   logic [BUF_AW-1:0] rd_ptr;
   logic [LVL_W-1:0]  fill_level;
   logic              do_write;
   logic              do_pop;

   assign do_write      = buf_write && !flush;
   assign do_pop        = word_pop && !flush;
   assign word_out      = mem[rd_ptr];
   assign block_ready   = (fill_level >= LVL_W'(BLOCK_WORDS));
   assign credit_return = do_pop;   // one credit per word sent

   always_ff @(posedge clk) begin
      if (do_write) mem[wr_ptr] <= buf_data;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         fill_level <= '0;
      end else if (flush) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         fill_level <= '0;
      end else begin
         if (do_write) wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is 2**BUF_AW
         if (do_pop)   rd_ptr <= rd_ptr + 1'b1;
         fill_level <= fill_level + LVL_W'(do_write) - LVL_W'(do_pop);
      end
   end

endmodule

// ==== hw/adma_reader.sv ====
//////////////////////////////////////////////////////////////////////
// RAM fetch engine, one word read per cycle while credits remain
// RAM read latency is fixed at one cycle, the write to the buffer
// follows one cycle after the data returns
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module adma_reader import sd_host_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              load,
   input  logic [ADDR_W-1:0] start_address,
   input  logic              words_left_zero,
   input  logic              flush,
   input  logic              credit_return,
   input  logic [WORD_W-1:0] data_from_ram,
   output logic              ram_read_enable,
   output logic [ADDR_W-1:0] ram_address,
   output logic              word_read,
   output logic              buf_write,
   output logic [WORD_W-1:0] buf_data
);

   logic [LVL_W-1:0]  credits;
   logic [ADDR_W-1:0] next_addr;
   logic              active;        // cleared by flush, stops fetching
   logic              read_pending;  // RAM answers this cycle

   assign ram_read_enable = active && !flush && !words_left_zero && (credits != '0);
   assign ram_address     = next_addr;
   assign word_read       = ram_read_enable;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         credits      <= LVL_W'(BUF_DEPTH);
         next_addr    <= '0;
         active       <= 1'b0;
         read_pending <= 1'b0;
         buf_write    <= 1'b0;
      end else if (load || flush) begin
         credits      <= LVL_W'(BUF_DEPTH);
         active       <= load;
         read_pending <= 1'b0;
         buf_write    <= 1'b0;
         if (load) next_addr <= start_address;
      end else begin
         read_pending <= ram_read_enable;
         buf_write    <= read_pending;
         if (ram_read_enable) next_addr <= next_addr + ADDR_W'(4);  // byte address

         unique case ({ram_read_enable, credit_return})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   // returned word held for the buffer write
   always_ff @(posedge clk) begin
      if (read_pending) buf_data <= data_from_ram;
   end

endmodule

// ==== hw/transfer_counters.sv ====
//////////////////////////////////////////////////////////////////////
// words-left and blocks-left counters plus the card busy timer
// timeout_hit flags the BUSY_TIMEOUT-th cycle of busy_wait
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module transfer_counters import sd_host_pkg::*; (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             load,
   input  logic [CNT_W-1:0] block_count,
   input  logic             word_read,
   input  logic             block_sent,
   input  logic             busy_wait,
   output logic             words_left_zero,
   output logic             blocks_left_zero,
   output logic             timeout_hit
);

   logic [WL_W-1:0]  words_left;
   logic [CNT_W-1:0] blocks_left;
   logic [TMR_W-1:0] busy_timer;

   assign words_left_zero  = (words_left == '0);
   assign blocks_left_zero = (blocks_left == '0);
   assign timeout_hit      = (busy_timer == TMR_W'(BUSY_TIMEOUT - 1));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         words_left  <= '0;
         blocks_left <= '0;
         busy_timer  <= '0;
      end else begin
         if (load) begin
            words_left  <= WL_W'(block_count) * WL_W'(BLOCK_WORDS);
            blocks_left <= block_count;
         end else begin
            if (word_read && !words_left_zero)   words_left  <= words_left - 1'b1;
            if (block_sent && !blocks_left_zero) blocks_left <= blocks_left - 1'b1;
         end

         busy_timer <= busy_wait ? busy_timer + 1'b1 : '0;
      end
   end

endmodule

// ==== hw/transfer_fsm.sv ====
//////////////////////////////////////////////////////////////////////
// transfer sequencer, one block on the bus at a time
// start is only taken in S_IDLE, error holds until the next start
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module transfer_fsm import sd_host_pkg::*; (
   input  logic clk,
   input  logic arst_n,
   input  logic start,
   input  logic card_busy,
   input  logic block_ready,
   input  logic block_sent,
   input  logic blocks_left_zero,
   input  logic timeout_hit,
   output logic load,
   output logic send_block,
   output logic busy_wait,
   output logic flush,
   output logic busy,
   output logic done,
   output logic error
);

   fsm_state_t state;
   fsm_state_t next_state;
   logic       in_flight;   // serializer owns a block
   logic       error_q;
   logic       go_error;

   assign load       = (state == S_IDLE) && start;
   assign send_block = (state == S_SEND) && !in_flight && block_ready && !blocks_left_zero;
   assign busy_wait  = (state == S_WAIT_BUSY);
   assign go_error   = busy_wait && card_busy && timeout_hit;
   assign flush      = (state == S_ERROR);
   assign busy       = (state != S_IDLE);
   assign done       = (state == S_DONE) || (state == S_ERROR);
   assign error      = error_q;

   always_comb begin
      next_state = state;
      unique case (state)
         S_IDLE: begin
            if (start) next_state = S_SEND;
         end
         S_SEND: begin
            if (in_flight && block_sent) begin
               next_state = S_WAIT_BUSY;
            end else if (!in_flight && blocks_left_zero) begin
               next_state = S_DONE;   // zero block count
            end
         end
         S_WAIT_BUSY: begin
            if (!card_busy) begin
               next_state = blocks_left_zero ? S_DONE : S_SEND;
            end else if (timeout_hit) begin
               next_state = S_ERROR;
            end
         end
         S_DONE:  next_state = S_IDLE;
         S_ERROR: next_state = S_IDLE;
         default: next_state = S_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= S_IDLE;
         in_flight <= 1'b0;
         error_q   <= 1'b0;
      end else begin
         state <= next_state;

         if (send_block) begin
            in_flight <= 1'b1;
         end else if (block_sent) begin
            in_flight <= 1'b0;
         end

         // high already during the S_ERROR done pulse
         if (load) begin
            error_q <= 1'b0;
         end else if (go_error) begin
            error_q <= 1'b1;
         end
      end
   end

endmodule

// ==== hw/sd_host_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared sizes, limits and state enums of the SD host write path
// BUF_DEPTH must be a power of two, the FIFO pointers wrap on overflow
// enum literals carry S_ and P_ prefixes to keep one package scope
//////////////////////////////////////////////////////////////////////

package sd_host_pkg;

   localparam int ADDR_W       = 32;
   localparam int WORD_W       = 32;
   localparam int BLOCK_WORDS  = 4;   // 16-byte block, short for simulation
   localparam int BUF_DEPTH    = 8;   // also the initial credit count
   localparam int CNT_W        = 16;
   localparam int BUSY_TIMEOUT = 64;  // max card busy cycles after a block
   localparam int CRC_BITS     = 16;

   // derived widths
   localparam int BUF_AW       = $clog2(BUF_DEPTH);
   localparam int LVL_W        = $clog2(BUF_DEPTH + 1);    // fill level and credits
   localparam int WL_W         = CNT_W + $clog2(BLOCK_WORDS);
   localparam int TMR_W        = $clog2(BUSY_TIMEOUT + 1);
   localparam int NIB_PER_WORD = WORD_W / 4;
   localparam int NIB_W        = $clog2(CRC_BITS);          // nibble and crc bit index
   localparam int WCNT_W       = $clog2(BLOCK_WORDS);

   // x^16 + x^12 + x^5 + 1
   localparam logic [CRC_BITS-1:0] CRC_POLY = 16'h1021;

   typedef enum logic [2:0] {
      S_IDLE,
      S_SEND,
      S_WAIT_BUSY,
      S_DONE,
      S_ERROR
   } fsm_state_t;

   typedef enum logic [2:0] {
      P_IDLE,
      P_START,
      P_DATA,
      P_CRC,
      P_STOP
   } dat_phase_t;

endpackage
